// ==== design/cordic_defines.svh ====
// Iteration count, widths, FP80 bias and queue depths for the CORDIC unit; include where needed
`ifndef CORDIC_DEFINES_SVH
`define CORDIC_DEFINES_SVH

// Micro-rotations per job
`define CORDIC_ITERS 50

// Q2.62 working format
`define CORDIC_FIX_W 64
`define CORDIC_FRAC_BITS 62

// FP80 exponent bias
`define FP80_BIAS 16383

// Queue depths and credits held after reset
`define CORDIC_REQ_DEPTH 2
`define CORDIC_RSP_DEPTH 2
`define CORDIC_RSP_CREDITS 2

`endif

// ==== design/cordic_num_pkg.sv ====
// Number formats for the CORDIC datapath and its model: FP80, Q2.62 and the arctangent constants
`include "cordic_defines.svh"

package cordic_num_pkg;

    // FP80 with explicit leading mantissa bit
    typedef struct packed {
        logic        sign;
        logic [14:0] exponent;
        logic [63:0] mantissa;
    } fp80_t;

    // Signed Q2.62
    typedef logic signed [`CORDIC_FIX_W-1:0] fix_t;

    // Micro-rotation index
    typedef logic [$clog2(`CORDIC_ITERS)-1:0] iter_t;

    // 1/K, the inverse CORDIC gain, used as the rotation start vector
    localparam fix_t inv_gain_q62 = 64'h26DD3B6A07DBAC00;

    // pi/4 rounded to Q2.62
    localparam fix_t quarter_pi_q62 = 64'h3243F6A8885A308D;

    // ========================================
    // Arctangent constants
    // ========================================

    // atan(2^-i) in Q2.62, rounded to nearest
    // Taylor series evaluated at 2^-126 scale, then rounded down to 2^-62
    // Series is alternating, so the partial sum never goes negative
    function automatic fix_t atan_q62(input int i);
        logic [127:0] acc;
        logic [127:0] term;
        int           e;
        acc = '0;
        // Series converges too slowly at x = 1
        if (i == 0) begin
            return quarter_pi_q62;
        end
        for (int k = 0; k < 64; k++) begin
            // Term k is 2^(126 - i*(2k+1)) / (2k+1)
            e = 126 - i * (2 * k + 1);
            if (e >= 0) begin
                term = (128'd1 << e) / 128'(2 * k + 1);
                if (k % 2 == 0) begin
                    acc = acc + term;
                end else begin
                    acc = acc - term;
                end
            end
        end
        // Round half up into the 62 fraction bits
        return fix_t'((acc + (128'd1 << 63)) >> 64);
    endfunction

endpackage

// ==== design/cordic_txn_pkg.sv ====
// Request, response and job formats exchanged with the CORDIC unit and inside it
package cordic_txn_pkg;

    // One bit, rotation or vectoring
    typedef enum logic {
        OP_ROTATE = 1'b0,
        OP_VECTOR = 1'b1
    } cordic_op_t;

    // Rotation: operand_a is the angle, operand_b ignored
    // Vectoring: operand_a is x, operand_b is y
    typedef struct packed {
        cordic_op_t            op;
        logic [3:0]            tag;
        cordic_num_pkg::fp80_t operand_a;
        cordic_num_pkg::fp80_t operand_b;
    } cordic_req_t;

    // Rotation: cos in result_a, sin in result_b
    // Vectoring: atan in result_a, K-scaled magnitude in result_b
    typedef struct packed {
        cordic_op_t            op;
        logic [3:0]            tag;
        cordic_num_pkg::fp80_t result_a;
        cordic_num_pkg::fp80_t result_b;
    } cordic_rsp_t;

    // Travels with a job in the rotator
    typedef struct packed {
        cordic_op_t op;
        logic [3:0] tag;
    } cordic_job_t;

endpackage

// ==== design/cordic_slot_queue.sv ====
// Small circular FIFO with a type-parameterized payload, used for the request and response queues
`timescale 1ns/10ps

module cordic_slot_queue #(
    parameter type payload_t = logic,
    parameter int  depth     = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         slots [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;

    // Wraps at depth, so depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // Pointers and occupancy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Slot storage
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    // Head shows a push one cycle later
    assign head      = slots[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == cnt_w'(depth));

    // A push into a full queue means the sender overspent its credits
    a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) !(pop && !not_empty));

endmodule

// ==== design/fp80_unpack_fixed.sv ====
// Converts one FP80 operand to Q2.62 fixed point, flushing zero and denormal inputs to zero
`timescale 1ns/10ps
`include "cordic_defines.svh"

module fp80_unpack_fixed (
    input  cordic_num_pkg::fp80_t value,
    output cordic_num_pkg::fix_t  fixed
);

    // Left shift that lands the FP80 binary point on the Q2.62 one
    // Works out to exponent - 16384
    int                       shift;
    logic [`CORDIC_FIX_W-1:0] magnitude;

    always_comb begin
        shift = int'(value.exponent) - `FP80_BIAS - (`CORDIC_FIX_W - 1) + `CORDIC_FRAC_BITS;
        if (value.exponent == '0) begin
            // Zero and denormals
            magnitude = '0;
        end else if (shift >= 0) begin
            magnitude = value.mantissa << shift;
        end else begin
            // Shifts of 64 or more drop everything
            magnitude = value.mantissa >> (-shift);
        end
        // Sign applied last, so -0 comes out as 0
        fixed = value.sign ? -$signed(magnitude) : $signed(magnitude);
    end

endmodule

// ==== design/cordic_rotator.sv ====
// CORDIC working registers x, y, z with one micro-rotation per step and the arctangent lookup
`timescale 1ns/10ps
`include "cordic_defines.svh"

module cordic_rotator (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load,
    input  cordic_txn_pkg::cordic_job_t load_job,
    input  cordic_num_pkg::fix_t        angle_or_x,
    input  cordic_num_pkg::fix_t        y_in,
    input  logic                        step,
    input  cordic_num_pkg::iter_t       iter,
    output cordic_num_pkg::fix_t        x,
    output cordic_num_pkg::fix_t        y,
    output cordic_num_pkg::fix_t        z,
    output cordic_txn_pkg::cordic_job_t job
);

    cordic_num_pkg::fix_t atan_rom [`CORDIC_ITERS];
    cordic_num_pkg::fix_t atan_step;
    cordic_num_pkg::fix_t x_shift;
    cordic_num_pkg::fix_t y_shift;
    cordic_num_pkg::fix_t x_next;
    cordic_num_pkg::fix_t y_next;
    cordic_num_pkg::fix_t z_next;
    logic                 rotate_pos;

    // ========================================
    // Arctangent ROM
    // ========================================

    for (genvar i = 0; i < `CORDIC_ITERS; i++) begin : g_atan
        localparam cordic_num_pkg::fix_t atan_c = cordic_num_pkg::atan_q62(i);
        assign atan_rom[i] = atan_c;
    end

    // ========================================
    // Micro-rotation
    // ========================================

    // Rotation drives z toward zero, vectoring drives y toward zero
    assign rotate_pos = (job.op == cordic_txn_pkg::OP_ROTATE) ? !z[$bits(z)-1] : y[$bits(y)-1];

    always_comb begin
        x_shift   = x >>> iter;
        y_shift   = y >>> iter;
        atan_step = atan_rom[iter];
        if (rotate_pos) begin
            // Counter-clockwise
            x_next = x - y_shift;
            y_next = y + x_shift;
            z_next = z - atan_step;
        end else begin
            x_next = x + y_shift;
            y_next = y - x_shift;
            z_next = z + atan_step;
        end
    end

    // Working vector
    always_ff @(posedge clk) begin
        if (load) begin
            if (load_job.op == cordic_txn_pkg::OP_ROTATE) begin
                // Pre-scaled by 1/K so cos and sin come out unscaled
                x <= cordic_num_pkg::inv_gain_q62;
                y <= '0;
                z <= angle_or_x;
            end else begin
                x <= angle_or_x;
                y <= y_in;
                z <= '0;
            end
        end else if (step) begin
            x <= x_next;
            y <= y_next;
            z <= z_next;
        end
    end

    // Op and tag of the job in flight
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            job <= '0;
        end else if (load) begin
            job <= load_job;
        end
    end

    // Controller must never start a job while one is rotating
    a_step_load_exclusive: assert property (@(posedge clk) disable iff (reset) !(step && load));

endmodule

// ==== design/fixed_pack_fp80.sv ====
// Normalizes the final CORDIC x, y, z into FP80 and registers the response for the output queue
`timescale 1ns/10ps
`include "cordic_defines.svh"

module fixed_pack_fp80 (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pack,
    input  cordic_txn_pkg::cordic_job_t job,
    input  cordic_num_pkg::fix_t        x,
    input  cordic_num_pkg::fix_t        y,
    input  cordic_num_pkg::fix_t        z,
    output cordic_txn_pkg::cordic_rsp_t rsp
);

    // Sign and magnitude, leading-zero count, left-justify
    // Exponent works out to 16384 - lz
    function automatic cordic_num_pkg::fp80_t fix_to_fp80(input cordic_num_pkg::fix_t v);
        cordic_num_pkg::fp80_t    f;
        logic [`CORDIC_FIX_W-1:0] mag;
        int                       lz;
        f   = '0;
        mag = v[`CORDIC_FIX_W-1] ? $unsigned(-v) : $unsigned(v);
        // Highest set bit wins
        lz  = `CORDIC_FIX_W;
        for (int b = 0; b < `CORDIC_FIX_W; b++) begin
            if (mag[b]) begin
                lz = `CORDIC_FIX_W - 1 - b;
            end
        end
        if (mag != '0) begin
            f.sign     = v[`CORDIC_FIX_W-1];
            f.mantissa = mag << lz;
            f.exponent = 15'(`FP80_BIAS + (`CORDIC_FIX_W - 1) - `CORDIC_FRAC_BITS - lz);
        end
        return f;
    endfunction

    // Response register, held until the output queue takes it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp <= '0;
        end else if (pack) begin
            rsp.op  <= job.op;
            rsp.tag <= job.tag;
            if (job.op == cordic_txn_pkg::OP_ROTATE) begin
                // cos, sin
                rsp.result_a <= fix_to_fp80(x);
                rsp.result_b <= fix_to_fp80(y);
            end else begin
                // atan, K-scaled magnitude
                rsp.result_a <= fix_to_fp80(z);
                rsp.result_b <= fix_to_fp80(x);
            end
        end
    end

endmodule

// ==== design/cordic_ctrl.sv ====
// Job sequencing FSM for the CORDIC unit with iteration count and credit flow on both sides
`timescale 1ns/10ps
`include "cordic_defines.svh"

module cordic_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_ready,
    output logic                  req_pop,
    output logic                  load,
    output logic                  step,
    output cordic_num_pkg::iter_t iter,
    output logic                  pack,
    output logic                  rsp_push,
    input  logic                  rsp_full,
    input  logic                  rsp_ready,
    output logic                  rsp_pop,
    input  logic                  rsp_credit,
    output logic                  req_credit
);

    // One spare count so an overflow shows up instead of wrapping
    localparam int credit_w = $clog2(`CORDIC_RSP_CREDITS + 2);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ITERATE,
        ST_PACK,
        ST_HOLD
    } state_t;

    state_t                state;
    cordic_num_pkg::iter_t iter_cnt;
    logic [credit_w-1:0]   credits;

    // ========================================
    // Strobes
    // ========================================

    // Pop and load on the same edge
    assign req_pop  = (state == ST_IDLE) && req_ready;
    assign load     = req_pop;
    assign step     = (state == ST_ITERATE);
    assign iter     = iter_cnt;
    assign pack     = (state == ST_PACK);
    // Finished job waits in the packer while the output queue is full
    assign rsp_push = (state == ST_HOLD) && !rsp_full;
    assign rsp_pop  = rsp_ready && (credits != '0);

    // Job FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= ST_IDLE;
            iter_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_ready) begin
                        state    <= ST_ITERATE;
                        iter_cnt <= '0;
                    end
                end
                ST_ITERATE: begin
                    if (iter_cnt == cordic_num_pkg::iter_t'(`CORDIC_ITERS - 1)) begin
                        state <= ST_PACK;
                    end else begin
                        iter_cnt <= iter_cnt + 1'b1;
                    end
                end
                ST_PACK: state <= ST_HOLD;
                ST_HOLD: begin
                    if (!rsp_full) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ========================================
    // Credits
    // ========================================

    // Consumer credits, up on return and down on each result sent
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= credit_w'(`CORDIC_RSP_CREDITS);
        end else if (rsp_credit && !rsp_pop) begin
            credits <= credits + 1'b1;
        end else if (rsp_pop && !rsp_credit) begin
            credits <= credits - 1'b1;
        end
    end

    // One credit back to the producer per popped request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_credit <= 1'b0;
        end else begin
            req_credit <= req_pop;
        end
    end

    // Consumer must never return more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= credit_w'(`CORDIC_RSP_CREDITS));

endmodule

// ==== design/cordic_unit.sv ====
// Top level of the credit-flow FP80 CORDIC unit; connects queues, converters, rotator and control
`timescale 1ns/10ps
`include "cordic_defines.svh"

module cordic_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req_valid,
    input  cordic_txn_pkg::cordic_req_t req,
    output logic                        req_credit,
    output logic                        rsp_valid,
    output cordic_txn_pkg::cordic_rsp_t rsp,
    input  logic                        rsp_credit
);

    cordic_txn_pkg::cordic_req_t req_head;
    cordic_txn_pkg::cordic_job_t load_job;
    cordic_txn_pkg::cordic_job_t run_job;
    cordic_txn_pkg::cordic_rsp_t pack_rsp;
    cordic_num_pkg::fix_t        fix_a;
    cordic_num_pkg::fix_t        fix_b;
    cordic_num_pkg::fix_t        x;
    cordic_num_pkg::fix_t        y;
    cordic_num_pkg::fix_t        z;
    cordic_num_pkg::iter_t       iter;
    logic                        req_ready;
    logic                        req_pop;
    logic                        load;
    logic                        step;
    logic                        pack;
    logic                        rsp_push;
    logic                        rsp_full;
    logic                        rsp_ready;
    logic                        rsp_pop;

    assign load_job  = '{op: req_head.op, tag: req_head.tag};
    assign rsp_valid = rsp_pop;

    // Input side, credit flow keeps it from overflowing
    cordic_slot_queue #(
        .payload_t (cordic_txn_pkg::cordic_req_t),
        .depth     (`CORDIC_REQ_DEPTH)
    ) u_req_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (req_valid),
        .push_data (req),
        .pop       (req_pop),
        .head      (req_head),
        .not_empty (req_ready),
        .full      ()
    );

    fp80_unpack_fixed u_unpack_a (.value(req_head.operand_a), .fixed(fix_a));
    fp80_unpack_fixed u_unpack_b (.value(req_head.operand_b), .fixed(fix_b));

    cordic_rotator u_rotator (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .load_job   (load_job),
        .angle_or_x (fix_a),
        .y_in       (fix_b),
        .step       (step),
        .iter       (iter),
        .x          (x),
        .y          (y),
        .z          (z),
        .job        (run_job)
    );

    fixed_pack_fp80 u_packer (
        .clk   (clk),
        .reset (reset),
        .pack  (pack),
        .job   (run_job),
        .x     (x),
        .y     (y),
        .z     (z),
        .rsp   (pack_rsp)
    );

    // Output side, drained only against consumer credits
    cordic_slot_queue #(
        .payload_t (cordic_txn_pkg::cordic_rsp_t),
        .depth     (`CORDIC_RSP_DEPTH)
    ) u_rsp_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (rsp_push),
        .push_data (pack_rsp),
        .pop       (rsp_pop),
        .head      (rsp),
        .not_empty (rsp_ready),
        .full      (rsp_full)
    );

    cordic_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .req_ready  (req_ready),
        .req_pop    (req_pop),
        .load       (load),
        .step       (step),
        .iter       (iter),
        .pack       (pack),
        .rsp_push   (rsp_push),
        .rsp_full   (rsp_full),
        .rsp_ready  (rsp_ready),
        .rsp_pop    (rsp_pop),
        .rsp_credit (rsp_credit),
        .req_credit (req_credit)
    );

endmodule

// ==== test/tb_cordic_model.svh ====
// Reference model of the CORDIC unit, included inside the testbench module to predict responses
`ifndef TB_CORDIC_MODEL_SVH
`define TB_CORDIC_MODEL_SVH

// 1/K for 50 micro-rotations, product of cos(atan(2^-i)), about 0.6072529350088812
localparam cordic_num_pkg::fix_t model_inv_gain = 64'h26DD3B6A07DBAC00;

// FP80 value is mantissa * 2^(exponent - bias - 63)
// Q2.62 scales that by 2^62, so the net shift is exponent - bias - 1
function automatic cordic_num_pkg::fix_t fp80_to_q62(input cordic_num_pkg::fp80_t v);
    int          scale;
    logic [63:0] mag;
    scale = int'(v.exponent) - `FP80_BIAS - 1;
    if (v.exponent == '0) begin
        // Zero and denormals flush to zero
        return '0;
    end
    if (scale >= 0) begin
        mag = v.mantissa << scale;
    end else begin
        mag = v.mantissa >> (-scale);
    end
    if (v.sign) begin
        return -cordic_num_pkg::fix_t'(mag);
    end
    return cordic_num_pkg::fix_t'(mag);
endfunction

// Bit 63 of Q2.62 weighs 2^1, so a leading one there means exponent bias + 1
// Each normalizing shift costs one step of exponent
function automatic cordic_num_pkg::fp80_t q62_to_fp80(input cordic_num_pkg::fix_t v);
    cordic_num_pkg::fp80_t f;
    logic [63:0]           mag;
    int                    exp_val;
    f = '0;
    if (v == 0) begin
        return f;
    end
    mag     = (v < 0) ? 64'(-v) : 64'(v);
    exp_val = `FP80_BIAS + 1;
    while (!mag[63]) begin
        mag     = mag << 1;
        exp_val = exp_val - 1;
    end
    f.sign     = (v < 0);
    f.exponent = 15'(exp_val);
    f.mantissa = mag;
    return f;
endfunction

// Full job: start vector, 50 micro-rotations, FP80 result
function automatic cordic_txn_pkg::cordic_rsp_t cordic_expected(
    input cordic_txn_pkg::cordic_req_t r
);
    cordic_txn_pkg::cordic_rsp_t e;
    cordic_num_pkg::fix_t        x;
    cordic_num_pkg::fix_t        y;
    cordic_num_pkg::fix_t        z;
    cordic_num_pkg::fix_t        xs;
    cordic_num_pkg::fix_t        ys;
    cordic_num_pkg::fix_t        d;
    e     = '0;
    e.op  = r.op;
    e.tag = r.tag;
    if (r.op == cordic_txn_pkg::OP_ROTATE) begin
        x = model_inv_gain;
        y = '0;
        z = fp80_to_q62(r.operand_a);
    end else begin
        x = fp80_to_q62(r.operand_a);
        y = fp80_to_q62(r.operand_b);
        z = '0;
    end
    for (int i = 0; i < `CORDIC_ITERS; i++) begin
        // d = +1 turns counter-clockwise
        if (r.op == cordic_txn_pkg::OP_ROTATE) begin
            d = (z < 0) ? -1 : 1;
        end else begin
            d = (y < 0) ? 1 : -1;
        end
        xs = x >>> i;
        ys = y >>> i;
        x  = x - d * ys;
        y  = y + d * xs;
        z  = z - d * cordic_num_pkg::atan_q62(i);
    end
    if (r.op == cordic_txn_pkg::OP_ROTATE) begin
        e.result_a = q62_to_fp80(x);
        e.result_b = q62_to_fp80(y);
    end else begin
        e.result_a = q62_to_fp80(z);
        e.result_b = q62_to_fp80(x);
    end
    return e;
endfunction

`endif

// ==== test/tb_cordic_unit.sv ====
// Testbench top that runs random mixed CORDIC jobs under credit flow and checks them against the model
`timescale 1ns/10ps
`include "cordic_defines.svh"

module tb_cordic_unit;

    // Four directed jobs ahead of the random ones
    localparam int num_requests = 64;
    localparam int cycle_limit  = 40000;

    logic                        clk;
    logic                        reset;
    logic                        req_valid;
    cordic_txn_pkg::cordic_req_t req;
    logic                        req_credit;
    logic                        rsp_valid;
    cordic_txn_pkg::cordic_rsp_t rsp;
    logic                        rsp_credit;

    int seed;
    int value_errors;
    int protocol_errors;
    int timeouts;
    int cycle;
    // Producer and consumer bookkeeping
    int sent;
    int received;
    int credits_back;
    int producer_credits;
    int unit_credits;
    int held_slots;
    cordic_txn_pkg::cordic_rsp_t expected_q[$];

    `include "tb_cordic_model.svh"

    cordic_unit DUT (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    always #50 clk = ~clk;

    // ========================================
    // Stimulus
    // ========================================

    function automatic logic [63:0] rand_bits64();
        return {$random(seed), $random(seed)};
    endfunction

    // Normal FP80 with exponent in [lo, hi]
    // With below_top the top binade stays under 1.5x
    function automatic cordic_num_pkg::fp80_t rand_fp80(input int lo, input int hi,
                                                        input logic below_top,
                                                        input logic neg_ok);
        cordic_num_pkg::fp80_t f;
        int                    r;
        r            = $random(seed);
        f.exponent   = 15'(lo + (r & 32'h7fff_ffff) % (hi - lo + 1));
        f.mantissa   = rand_bits64();
        f.mantissa[63] = 1'b1;
        if (below_top && f.exponent == 15'(hi)) begin
            f.mantissa[62] = 1'b0;
        end
        f.sign = neg_ok && r[30];
        return f;
    endfunction

    function automatic cordic_txn_pkg::cordic_req_t make_request(input int idx);
        cordic_txn_pkg::cordic_req_t r;
        int                          pick;
        r     = '0;
        r.tag = 4'(idx);
        pick  = $random(seed);
        case (idx)
            // Angle +0
            0: r.op = cordic_txn_pkg::OP_ROTATE;
            // Denormal angle acts as zero
            1: begin
                r.op                 = cordic_txn_pkg::OP_ROTATE;
                r.operand_a.mantissa = rand_bits64();
            end
            // x = 0.5 with a denormal y
            2: begin
                r.op                 = cordic_txn_pkg::OP_VECTOR;
                r.operand_a.exponent = 15'(`FP80_BIAS - 1);
                r.operand_a.mantissa = 64'h8000_0000_0000_0000;
                r.operand_b.mantissa = rand_bits64();
            end
            // Angle -0.75
            3: begin
                r.op        = cordic_txn_pkg::OP_ROTATE;
                r.operand_a = '{sign: 1'b1, exponent: 15'(`FP80_BIAS - 1),
                                mantissa: 64'hC000_0000_0000_0000};
            end
            default: begin
                if (pick[0]) begin
                    r.op        = cordic_txn_pkg::OP_ROTATE;
                    r.operand_a = rand_fp80(`FP80_BIAS - 20, `FP80_BIAS, 1'b1, 1'b1);
                    r.operand_b = rand_fp80(`FP80_BIAS - 20, `FP80_BIAS, 1'b1, 1'b1);
                end else begin
                    r.op        = cordic_txn_pkg::OP_VECTOR;
                    r.operand_a = rand_fp80(`FP80_BIAS - 2, `FP80_BIAS - 1, 1'b1, 1'b0);
                    r.operand_b = rand_fp80(`FP80_BIAS - 13, `FP80_BIAS - 1, 1'b1, 1'b1);
                end
                // Now and then a zero-exponent operand
                if (pick[4:2] == 3'd0) begin
                    if (r.op == cordic_txn_pkg::OP_ROTATE) begin
                        r.operand_a.exponent = '0;
                    end else begin
                        r.operand_b.exponent = '0;
                    end
                end
            end
        endcase
        return r;
    endfunction

    // Runs 1 ns after the rising edge
    task automatic drive_inputs();
        int r;
        r          = $random(seed);
        req_valid  = 1'b0;
        rsp_credit = 1'b0;
        if (sent < num_requests && producer_credits > 0 && r[1:0] != 2'b00) begin
            req       = make_request(sent);
            req_valid = 1'b1;
            expected_q.push_back(cordic_expected(req));
            producer_credits--;
            sent++;
        end
        // Stingy consumer in the first half lets the output queue fill up
        if (held_slots > 0 && ((sent < num_requests / 2) ? (r[5:3] == 3'd0) : !r[3])) begin
            rsp_credit = 1'b1;
            held_slots--;
        end
    endtask

    // ========================================
    // Checks
    // ========================================

    task automatic check_value(input string name, input logic [79:0] got,
                               input logic [79:0] expected);
        if (got !== expected) begin
            $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, expected);
            value_errors++;
        end
    endtask

    // Runs on the falling edge, where DUT outputs are settled
    task automatic sample_outputs();
        cordic_txn_pkg::cordic_rsp_t exp_rsp;
        if (req_credit) begin
            if (credits_back >= sent) begin
                $display("Error at %0d ns: req_credit pulse with no request outstanding", $time);
                protocol_errors++;
            end else begin
                credits_back++;
                producer_credits++;
            end
        end
        // Popped and unanswered jobs fit in the engine plus the output queue
        if (credits_back - received > 1 + `CORDIC_RSP_DEPTH) begin
            $display("Error at %0d ns: credit returned for a request not yet taken", $time);
            protocol_errors++;
        end
        if (rsp_valid) begin
            // Consumer credits are spent before this cycle's return counts
            if (unit_credits == 0) begin
                $display("Error at %0d ns: response sent without a consumer credit", $time);
                protocol_errors++;
            end else begin
                unit_credits--;
            end
            held_slots++;
            if (expected_q.size() == 0) begin
                $display("Error at %0d ns: response with no request outstanding", $time);
                protocol_errors++;
            end else begin
                exp_rsp = expected_q.pop_front();
                check_value("rsp.op", 80'(rsp.op), 80'(exp_rsp.op));
                check_value("rsp.tag", 80'(rsp.tag), 80'(exp_rsp.tag));
                check_value("rsp.result_a", rsp.result_a, exp_rsp.result_a);
                check_value("rsp.result_b", rsp.result_b, exp_rsp.result_b);
            end
            received++;
        end
        if (rsp_credit) begin
            unit_credits++;
        end
    endtask

    // ========================================
    // Sequence
    // ========================================

    initial begin
        seed             = 93285;
        clk              = 1'b0;
        reset            = 1'b1;
        req_valid        = 1'b0;
        req              = '0;
        rsp_credit       = 1'b0;
        value_errors     = 0;
        protocol_errors  = 0;
        timeouts         = 0;
        sent             = 0;
        received         = 0;
        credits_back     = 0;
        producer_credits = `CORDIC_REQ_DEPTH;
        unit_credits     = `CORDIC_RSP_CREDITS;
        held_slots       = 0;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;

        // Run until every request is answered or the cycle limit is hit
        cycle = 0;
        while ((sent < num_requests || received < num_requests) && cycle < cycle_limit) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            sample_outputs();
            cycle++;
        end
        if (cycle >= cycle_limit) begin
            $display("Timeout: %0d of %0d responses after %0d cycles",
                     received, num_requests, cycle);
            timeouts++;
        end

        // Quiet window where nothing more may come out
        repeat (100) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            sample_outputs();
        end
        if (credits_back != sent) begin
            $display("Error: %0d req_credit pulses for %0d requests", credits_back, sent);
            protocol_errors++;
        end

        $display("Errors: %0d value mismatches, %0d protocol errors, %0d timeouts",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+design
+incdir+test
design/cordic_num_pkg.sv
design/cordic_txn_pkg.sv
design/cordic_slot_queue.sv
design/fp80_unpack_fixed.sv
design/cordic_rotator.sv
design/fixed_pack_fp80.sv
design/cordic_ctrl.sv
design/cordic_unit.sv
test/tb_cordic_unit.sv

// ==== Makefile ====
# Verilator build and run of the CORDIC unit testbench

SOURCES := verilog.f $(wildcard design/*.sv design/*.svh test/*.sv test/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_cordic_unit
	@out="$$(./obj_dir/Vtb_cordic_unit)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

obj_dir/Vtb_cordic_unit: $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_cordic_unit -f verilog.f

clean:
	rm -rf obj_dir
